//--- vexec.f
rtl/vexec_pkg.sv
rtl/vector_lane.sv
rtl/reduction_unit.sv
rtl/lsu_addr_gen.sv
rtl/ex_mem_latch.sv
rtl/vexec_top.sv
test/vexec_assertions.sv
test/vexec_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the vexec testbench with Verilator
# the exit status is nonzero when the simulation fails
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Mdir obj_dir --top-module vexec_tb -f vexec.f \
  && ./obj_dir/Vvexec_tb \
  || exit 1

//--- test/vexec_tb.sv
`timescale 1ns/100ps

module vexec_tb;

  import vexec_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 3;
  localparam int N_ALU = 60;
  localparam int N_MINMAX = 60;
  localparam int N_RED = 40;
  localparam int N_MEM = 10;
  localparam int TEST_CYCLES = RESET_CYCLES + N_ALU + N_MINMAX + N_RED + 3 * (N_MEM + 1) + 20;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 100;

  logic        CLK;
  logic        nRST;
  logic        valid;
  fu_t         fu;
  aluop_t      aluop;
  sew_t        sew;
  sew_t        eew;
  opsrc_t      opsrc;
  stride_t     stride;
  logic        group_first;
  vreg_t       vd;
  logic [1:0]  wen;
  logic [31:0] vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1;
  logic [31:0] imm, xs1, xs2, stride_val, storedata0, storedata1;
  logic        stall;
  logic        flush;
  logic        ex_valid, ex_load, ex_store;
  logic [31:0] ex_result0, ex_result1, ex_storedata0, ex_storedata1;
  logic [1:0]  ex_wen;
  vreg_t       ex_vd;

  // expected state of the memory stage and the address buffer
  logic        exp_valid = 1'b0;
  logic        exp_load = 1'b0;
  logic        exp_store = 1'b0;
  logic [1:0]  exp_wen = 2'b00;
  vreg_t       exp_vd = '0;
  logic [31:0] exp_r0, exp_r1, exp_sd0, exp_sd1;
  logic [31:0] model_buf = 32'h0;
  logic        data_known = 1'b0;
  logic [31:0] lfsr = 32'h396eb6e5;
  string       test_name = "reset";

  vexec_top #(.DATA_W(32)) i_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the test did not finish in %0d cycles", WATCHDOG_CYCLES);
    abort_run("timeout");
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // x is the left operand, ties keep y for min and x for max
  function automatic logic [31:0] ref_alu(input aluop_t op, input sew_t w,
                                          input logic [31:0] x, input logic [31:0] y);
    logic [31:0] mask;
    logic [31:0] sbit;
    logic        x_lt_y;
    logic [31:0] res;
    case (w)
      SEW8:    mask = 32'h0000_00ff;
      SEW16:   mask = 32'h0000_ffff;
      default: mask = 32'hffff_ffff;
    endcase
    // flipping the sign bit turns the signed compare into an unsigned one
    sbit = (op == VALU_MIN || op == VALU_MAX) ? (mask ^ (mask >> 1)) : 32'h0;
    x_lt_y = ((x & mask) ^ sbit) < ((y & mask) ^ sbit);
    case (op)
      VALU_ADD:            res = x + y;
      VALU_AND:            res = x & y;
      VALU_OR:             res = x | y;
      VALU_XOR:            res = x ^ y;
      VALU_MIN, VALU_MINU: res = x_lt_y ? x : y;
      default:             res = x_lt_y ? y : x;
    endcase
    return res;
  endfunction

  function automatic logic [31:0] lane_ref(input opsrc_t src, input logic [31:0] v1,
                                           input logic [31:0] v2);
    logic [31:0] a;
    a = (src == SRC_V) ? v1 : (src == SRC_I) ? imm : xs1;
    return ref_alu(aluop, sew, v2, a);
  endfunction

  task automatic abort_run(input string why);
    $display("Simulation finished: FAIL");
    $fatal(1, why);
  endtask

  task automatic check_val(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
      abort_run("output mismatch");
    end
  endtask

  // reference model, sees the inputs the DUT samples at this edge
  always @(posedge CLK) begin
    logic [31:0] r0, r1, a0, a1, step;
    step = (stride == STRIDE_CONST) ? stride_val :
           (eew == SEW8) ? 32'd1 : (eew == SEW16) ? 32'd2 : 32'd4;
    a0 = (stride == STRIDE_INDEX) ? xs1 + vs2_lane0 : group_first ? xs1 : model_buf;
    a1 = (stride == STRIDE_INDEX) ? xs1 + vs2_lane1 : a0 + step;
    r0 = lane_ref(opsrc, vs1_lane0, vs2_lane0);
    r1 = lane_ref(opsrc, vs1_lane1, vs2_lane1);
    if (!nRST || flush) begin
      {exp_valid, exp_load, exp_store, exp_wen} = '0;
      model_buf = 32'h0;
    end else if (!stall) begin
      exp_valid = valid;
      exp_load = valid && (fu == FU_LOAD);
      exp_store = valid && (fu == FU_STORE);
      exp_wen = valid ? wen : 2'b00;
      if (valid && (fu == FU_LOAD || fu == FU_STORE)) begin
        model_buf = a1 + step;
      end
    end
    if (nRST && flush) begin
      {exp_r0, exp_r1, exp_vd, exp_sd0, exp_sd1} = '0;
      data_known = 1'b1;
    end else if (nRST && !stall) begin
      case (fu)
        FU_REDUCE:         {exp_r0, exp_r1} = {ref_alu(aluop, sew, r0, r1), 32'h0};
        FU_MOVE:           {exp_r0, exp_r1} = {vs2_lane0, vs2_lane1};
        FU_LOAD, FU_STORE: {exp_r0, exp_r1} = {a0, a1};
        default:           {exp_r0, exp_r1} = {r0, r1};
      endcase
      {exp_vd, exp_sd0, exp_sd1} = {vd, storedata0, storedata1};
      data_known = 1'b1;
    end
  end

  // outputs are settled half a cycle after the edge
  always @(negedge CLK) begin
    check_val("ex_valid", 32'(exp_valid), 32'(ex_valid));
    check_val("ex_load", 32'(exp_load), 32'(ex_load));
    check_val("ex_store", 32'(exp_store), 32'(ex_store));
    check_val("ex_wen", 32'(exp_wen), 32'(ex_wen));
    if (data_known) begin
      check_val("ex_result0", exp_r0, ex_result0);
      check_val("ex_result1", exp_r1, ex_result1);
      check_val("ex_vd", 32'(exp_vd), 32'(ex_vd));
      check_val("ex_storedata0", exp_sd0, ex_storedata0);
      check_val("ex_storedata1", exp_sd1, ex_storedata1);
    end
  end

  task automatic drive_idle();
    @(posedge CLK);
    valid <= 1'b0;
    group_first <= 1'b0;
    stall <= 1'b0;
    flush <= 1'b0;
  endtask

  task automatic drive_instr(input fu_t f, input logic minmax, input stride_t st,
                             input logic first, input logic stl, input logic fls);
    @(posedge CLK);
    valid <= 1'b1;
    fu <= f;
    if (minmax) begin
      aluop <= aluop_t'(3'(4 + take_bits(2)));
    end else begin
      aluop <= aluop_t'(3'(take_bits(3)));
    end
    sew <= sew_t'(2'(take_bits(8) % 3));
    eew <= sew_t'(2'(take_bits(8) % 3));
    opsrc <= opsrc_t'(2'(take_bits(8) % 3));
    stride <= st;
    group_first <= first;
    vd <= vreg_t'(take_bits(5));
    wen <= 2'(take_bits(2));
    {vs1_lane0, vs1_lane1} <= {take_bits(32), take_bits(32)};
    {vs2_lane0, vs2_lane1} <= {take_bits(32), take_bits(32)};
    {imm, xs1, xs2} <= {take_bits(32), take_bits(32), take_bits(32)};
    stride_val <= take_bits(12);
    {storedata0, storedata1} <= {take_bits(32), take_bits(32)};
    stall <= stl;
    flush <= fls;
  endtask

  initial begin
    nRST = 1'b0;
    // a store is presented during reset, only the reset keeps the stage empty
    valid = 1'b1;
    fu = FU_STORE;
    wen = 2'b11;
    group_first = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    vd = '0;
    aluop = VALU_ADD;
    sew = SEW8;
    eew = SEW8;
    opsrc = SRC_V;
    stride = STRIDE_UNIT;
    {vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1} = '0;
    {imm, xs1, xs2, stride_val, storedata0, storedata1} = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    nRST <= 1'b1;
    valid <= 1'b0;
    repeat (2) drive_idle();
    test_name = "alu_random";
    repeat (N_ALU) drive_instr(FU_ALU, 1'b0, STRIDE_UNIT, 1'b0, 1'b0, 1'b0);
    test_name = "min_max_sew";
    repeat (N_MINMAX) drive_instr(FU_ALU, 1'b1, STRIDE_UNIT, 1'b0, 1'b0, 1'b0);
    test_name = "reduce";
    repeat (N_RED) drive_instr(FU_REDUCE, (take_bits(1) == 32'd1), STRIDE_UNIT, 1'b0, 1'b0, 1'b0);
    test_name = "mem_stride";
    for (int s = 0; s < 3; s++) begin
      for (int g = 0; g < N_MEM; g++) begin
        // second start of a group mid stream restarts from xs1
        drive_instr((g % 2 == 1) ? FU_STORE : FU_LOAD, 1'b0, stride_t'(2'(s)),
                    (g == 0) || (g == N_MEM / 2), 1'b0, 1'b0);
      end
      drive_idle();
    end
    test_name = "stall_flush";
    drive_instr(FU_LOAD, 1'b0, STRIDE_CONST, 1'b1, 1'b0, 1'b0);
    drive_instr(FU_LOAD, 1'b0, STRIDE_CONST, 1'b0, 1'b0, 1'b0);
    repeat (3) drive_instr(FU_STORE, 1'b0, STRIDE_CONST, 1'b0, 1'b1, 1'b0);
    drive_instr(FU_LOAD, 1'b0, STRIDE_CONST, 1'b0, 1'b0, 1'b0);
    drive_instr(FU_ALU, 1'b0, STRIDE_UNIT, 1'b0, 1'b1, 1'b1);
    drive_instr(FU_LOAD, 1'b0, STRIDE_UNIT, 1'b0, 1'b0, 1'b0);
    drive_instr(FU_STORE, 1'b0, STRIDE_UNIT, 1'b0, 1'b0, 1'b1);
    repeat (4) drive_instr(FU_MOVE, 1'b0, STRIDE_UNIT, 1'b0, 1'b0, 1'b0);
    drive_instr(FU_LOAD, 1'b0, STRIDE_UNIT, 1'b0, 1'b0, 1'b0);
    repeat (3) drive_idle();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- test/vexec_assertions.sv
`timescale 1ns/100ps

module vexec_assertions #(
  parameter int DATA_W = 32
) (
  input logic              CLK,
  input logic              nRST,
  input logic              stall,
  input logic              flush,
  input logic              ex_valid,
  input logic              ex_load,
  input logic              ex_store,
  input logic [1:0]        ex_wen,
  input logic [DATA_W-1:0] ex_result0,
  input logic [DATA_W-1:0] ex_result1
);

  // a flushed stage carries nothing into memory
  flush_clears_valid: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !ex_valid) else $error("flush did not clear ex_valid");

  // back-pressure freezes the memory stage
  stall_holds_outputs: assert property (@(posedge CLK) disable iff (!nRST)
    (stall && !flush) |=> ($stable(ex_valid) && $stable(ex_load) && $stable(ex_store)
      && $stable(ex_wen) && $stable(ex_result0) && $stable(ex_result1)))
    else $error("memory stage outputs changed during stall");

  no_write_when_invalid: assert property (@(posedge CLK) disable iff (!nRST)
    !ex_valid |-> (ex_wen == 2'b00)) else $error("ex_wen set while ex_valid is low");

endmodule

bind ex_mem_latch vexec_assertions #(.DATA_W(DATA_W)) i_assertions (
  .CLK(CLK), .nRST(nRST), .stall(stall), .flush(flush), .ex_valid(ex_valid),
  .ex_load(ex_load), .ex_store(ex_store), .ex_wen(ex_wen),
  .ex_result0(ex_result0), .ex_result1(ex_result1)
);

//--- rtl/vexec_top.sv
`timescale 1ns/100ps

module vexec_top #(
  parameter int DATA_W = vexec_pkg::DATA_W
) (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               valid,
  input  vexec_pkg::fu_t     fu,
  input  vexec_pkg::aluop_t  aluop,
  input  vexec_pkg::sew_t    sew,
  input  vexec_pkg::opsrc_t  opsrc,
  input  vexec_pkg::stride_t stride,
  input  vexec_pkg::sew_t    eew,
  input  logic               group_first,
  input  vexec_pkg::vreg_t   vd,
  input  logic [1:0]         wen,
  input  logic [DATA_W-1:0]  vs1_lane0,
  input  logic [DATA_W-1:0]  vs1_lane1,
  input  logic [DATA_W-1:0]  vs2_lane0,
  input  logic [DATA_W-1:0]  vs2_lane1,
  input  logic [DATA_W-1:0]  imm,
  input  logic [DATA_W-1:0]  xs1,
  // reserved, second operand is always vs2 for now
  input  logic [DATA_W-1:0]  xs2,
  input  logic [DATA_W-1:0]  stride_val,
  input  logic [DATA_W-1:0]  storedata0,
  input  logic [DATA_W-1:0]  storedata1,
  input  logic               stall,
  input  logic               flush,
  output logic               ex_valid,
  output logic               ex_load,
  output logic               ex_store,
  output logic [DATA_W-1:0]  ex_result0,
  output logic [DATA_W-1:0]  ex_result1,
  output logic [1:0]         ex_wen,
  output vexec_pkg::vreg_t   ex_vd,
  output logic [DATA_W-1:0]  ex_storedata0,
  output logic [DATA_W-1:0]  ex_storedata1
);

  import vexec_pkg::*;

  logic [DATA_W-1:0] lane0_result, lane1_result, red_result;
  logic [DATA_W-1:0] addr0, addr1;
  logic              advance;

  // a memory access that actually leaves execute moves the address stream on
  assign advance = valid && ((fu == FU_LOAD) || (fu == FU_STORE)) && !stall && !flush;

  vector_lane #(.DATA_W(DATA_W)) i_lane0 (
    .opsrc(opsrc), .aluop(aluop), .sew(sew), .vs1(vs1_lane0), .vs2(vs2_lane0),
    .imm(imm), .xs1(xs1), .lane_result(lane0_result)
  );

  vector_lane #(.DATA_W(DATA_W)) i_lane1 (
    .opsrc(opsrc), .aluop(aluop), .sew(sew), .vs1(vs1_lane1), .vs2(vs2_lane1),
    .imm(imm), .xs1(xs1), .lane_result(lane1_result)
  );

  reduction_unit #(.DATA_W(DATA_W)) i_reduce (
    .aluop(aluop), .sew(sew), .lane0_result(lane0_result),
    .lane1_result(lane1_result), .red_result(red_result)
  );

  lsu_addr_gen #(.DATA_W(DATA_W)) i_addr_gen (
    .CLK(CLK), .nRST(nRST), .advance(advance), .flush(flush),
    .group_first(group_first), .stride(stride), .eew(eew), .xs1(xs1),
    .stride_val(stride_val), .vs2_lane0(vs2_lane0), .vs2_lane1(vs2_lane1),
    .addr0(addr0), .addr1(addr1)
  );

  ex_mem_latch #(.DATA_W(DATA_W)) i_latch (
    .CLK(CLK), .nRST(nRST), .stall(stall), .flush(flush), .valid(valid), .fu(fu),
    .lane0_result(lane0_result), .lane1_result(lane1_result), .red_result(red_result),
    .addr0(addr0), .addr1(addr1), .vs2_lane0(vs2_lane0), .vs2_lane1(vs2_lane1),
    .vd(vd), .wen(wen), .storedata0(storedata0), .storedata1(storedata1),
    .ex_valid(ex_valid), .ex_load(ex_load), .ex_store(ex_store),
    .ex_result0(ex_result0), .ex_result1(ex_result1), .ex_wen(ex_wen), .ex_vd(ex_vd),
    .ex_storedata0(ex_storedata0), .ex_storedata1(ex_storedata1)
  );

endmodule

//--- rtl/ex_mem_latch.sv
`timescale 1ns/100ps

module ex_mem_latch #(
  parameter int DATA_W = 32
) (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               stall,
  input  logic               flush,
  input  logic               valid,
  input  vexec_pkg::fu_t     fu,
  input  logic [DATA_W-1:0]  lane0_result,
  input  logic [DATA_W-1:0]  lane1_result,
  input  logic [DATA_W-1:0]  red_result,
  input  logic [DATA_W-1:0]  addr0,
  input  logic [DATA_W-1:0]  addr1,
  input  logic [DATA_W-1:0]  vs2_lane0,
  input  logic [DATA_W-1:0]  vs2_lane1,
  input  vexec_pkg::vreg_t   vd,
  input  logic [1:0]         wen,
  input  logic [DATA_W-1:0]  storedata0,
  input  logic [DATA_W-1:0]  storedata1,
  output logic               ex_valid,
  output logic               ex_load,
  output logic               ex_store,
  output logic [DATA_W-1:0]  ex_result0,
  output logic [DATA_W-1:0]  ex_result1,
  output logic [1:0]         ex_wen,
  output vexec_pkg::vreg_t   ex_vd,
  output logic [DATA_W-1:0]  ex_storedata0,
  output logic [DATA_W-1:0]  ex_storedata1
);

  import vexec_pkg::*;

  logic [DATA_W-1:0] sel0;
  logic [DATA_W-1:0] sel1;

  // per-lane result by functional unit
  always_comb begin
    case (fu)
      FU_REDUCE:         {sel0, sel1} = {red_result, {DATA_W{1'b0}}};
      FU_MOVE:           {sel0, sel1} = {vs2_lane0, vs2_lane1};
      FU_LOAD, FU_STORE: {sel0, sel1} = {addr0, addr1};
      default:           {sel0, sel1} = {lane0_result, lane1_result};
    endcase
  end

  // control, qualified by valid
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_valid <= 1'b0;
      ex_load  <= 1'b0;
      ex_store <= 1'b0;
      ex_wen   <= '0;
    end else if (flush) begin
      ex_valid <= 1'b0;
      ex_load  <= 1'b0;
      ex_store <= 1'b0;
      ex_wen   <= '0;
    end else if (!stall) begin
      ex_valid <= valid;
      ex_load  <= valid && (fu == FU_LOAD);
      ex_store <= valid && (fu == FU_STORE);
      ex_wen   <= valid ? wen : 2'b00;
    end
  end

  // data path
  always_ff @(posedge CLK) begin
    if (flush) begin
      ex_result0    <= '0;
      ex_result1    <= '0;
      ex_vd         <= '0;
      ex_storedata0 <= '0;
      ex_storedata1 <= '0;
    end else if (!stall) begin
      ex_result0    <= sel0;
      ex_result1    <= sel1;
      ex_vd         <= vd;
      ex_storedata0 <= storedata0;
      ex_storedata1 <= storedata1;
    end
  end

endmodule

//--- rtl/lsu_addr_gen.sv
`timescale 1ns/100ps

module lsu_addr_gen #(
  parameter int DATA_W = 32
) (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               advance,
  input  logic               flush,
  input  logic               group_first,
  input  vexec_pkg::stride_t stride,
  input  vexec_pkg::sew_t    eew,
  input  logic [DATA_W-1:0]  xs1,
  input  logic [DATA_W-1:0]  stride_val,
  input  logic [DATA_W-1:0]  vs2_lane0,
  input  logic [DATA_W-1:0]  vs2_lane1,
  output logic [DATA_W-1:0]  addr0,
  output logic [DATA_W-1:0]  addr1
);

  import vexec_pkg::*;

  logic [DATA_W-1:0] addr_buf;
  logic [DATA_W-1:0] elem_bytes;
  logic [DATA_W-1:0] step;
  logic [DATA_W-1:0] base;

  always_comb begin
    case (eew)
      SEW8:    elem_bytes = DATA_W'(1);
      SEW16:   elem_bytes = DATA_W'(2);
      default: elem_bytes = DATA_W'(4);
    endcase
  end

  assign step = (stride == STRIDE_CONST) ? stride_val : elem_bytes;

  // a new group restarts from the scalar base, otherwise continue the stream
  assign base = group_first ? xs1 : addr_buf;

  always_comb begin
    if (stride == STRIDE_INDEX) begin
      addr0 = xs1 + vs2_lane0;
      addr1 = xs1 + vs2_lane1;
    end else begin
      addr0 = base;
      addr1 = base + step;
    end
  end

  // next group starts one step past lane 1
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      addr_buf <= '0;
    end else if (flush) begin
      addr_buf <= '0;
    end else if (advance) begin
      addr_buf <= addr1 + step;
    end
  end

endmodule

//--- rtl/reduction_unit.sv
`timescale 1ns/100ps

module reduction_unit #(
  parameter int DATA_W = 32
) (
  input  vexec_pkg::aluop_t  aluop,
  input  vexec_pkg::sew_t    sew,
  input  logic [DATA_W-1:0]  lane0_result,
  input  logic [DATA_W-1:0]  lane1_result,
  output logic [DATA_W-1:0]  red_result
);

  import vexec_pkg::*;

  logic signed [DATA_W:0] x_ext;
  logic signed [DATA_W:0] y_ext;
  logic                   sgn;
  logic                   lt;

  // lane0 is the left operand, same ordering as the lane alu
  always_comb begin
    sgn = (aluop == VALU_MIN) || (aluop == VALU_MAX);
    case (sew)
      SEW8: begin
        x_ext = {{(DATA_W-7){sgn & lane0_result[7]}}, lane0_result[7:0]};
        y_ext = {{(DATA_W-7){sgn & lane1_result[7]}}, lane1_result[7:0]};
      end
      SEW16: begin
        x_ext = {{(DATA_W-15){sgn & lane0_result[15]}}, lane0_result[15:0]};
        y_ext = {{(DATA_W-15){sgn & lane1_result[15]}}, lane1_result[15:0]};
      end
      default: begin
        x_ext = {sgn & lane0_result[DATA_W-1], lane0_result};
        y_ext = {sgn & lane1_result[DATA_W-1], lane1_result};
      end
    endcase
    lt = x_ext < y_ext;
  end

  always_comb begin
    case (aluop)
      VALU_ADD:             red_result = lane0_result + lane1_result;
      VALU_AND:             red_result = lane0_result & lane1_result;
      VALU_OR:              red_result = lane0_result | lane1_result;
      VALU_XOR:             red_result = lane0_result ^ lane1_result;
      VALU_MIN, VALU_MINU:  red_result = lt ? lane0_result : lane1_result;
      VALU_MAX, VALU_MAXU:  red_result = lt ? lane1_result : lane0_result;
      default:              red_result = '0;
    endcase
  end

endmodule

//--- rtl/vector_lane.sv
`timescale 1ns/100ps

module vector_lane #(
  parameter int DATA_W = 32
) (
  input  vexec_pkg::opsrc_t  opsrc,
  input  vexec_pkg::aluop_t  aluop,
  input  vexec_pkg::sew_t    sew,
  input  logic [DATA_W-1:0]  vs1,
  input  logic [DATA_W-1:0]  vs2,
  input  logic [DATA_W-1:0]  imm,
  input  logic [DATA_W-1:0]  xs1,
  output logic [DATA_W-1:0]  lane_result
);

  import vexec_pkg::*;

  logic [DATA_W-1:0] opa;
  logic              signed_op;
  logic              lt;

  // widen the low sew bits by one so signed and unsigned share one compare
  function automatic logic signed [DATA_W:0] cmp_ext(input logic [DATA_W-1:0] v,
                                                     input sew_t w,
                                                     input logic sgn);
    logic msb;
    case (w)
      SEW8: begin
        msb = sgn & v[7];
        return {{(DATA_W-7){msb}}, v[7:0]};
      end
      SEW16: begin
        msb = sgn & v[15];
        return {{(DATA_W-15){msb}}, v[15:0]};
      end
      default: begin
        msb = sgn & v[DATA_W-1];
        return {msb, v};
      end
    endcase
  endfunction

  // first operand select, scalar and immediate are broadcast
  always_comb begin
    case (opsrc)
      SRC_V:   opa = vs1;
      SRC_I:   opa = imm;
      SRC_X:   opa = xs1;
      default: opa = '0;
    endcase
  end

  assign signed_op = (aluop == VALU_MIN) || (aluop == VALU_MAX);
  assign lt = cmp_ext(vs2, sew, signed_op) < cmp_ext(opa, sew, signed_op);

  always_comb begin
    case (aluop)
      VALU_ADD:             lane_result = vs2 + opa;
      VALU_AND:             lane_result = vs2 & opa;
      VALU_OR:              lane_result = vs2 | opa;
      VALU_XOR:             lane_result = vs2 ^ opa;
      // ties pick opa for min, vs2 for max
      VALU_MIN, VALU_MINU:  lane_result = lt ? vs2 : opa;
      VALU_MAX, VALU_MAXU:  lane_result = lt ? opa : vs2;
      default:              lane_result = '0;
    endcase
  end

endmodule

//--- rtl/vexec_pkg.sv
package vexec_pkg;

  // default data and address width
  parameter int DATA_W = 32;

  // functional unit of the instruction in execute
  typedef enum logic [2:0] {
    FU_ALU,
    FU_REDUCE,
    FU_MOVE,
    FU_LOAD,
    FU_STORE
  } fu_t;

  // integer alu opcodes, min/max come in signed and unsigned flavours
  typedef enum logic [2:0] {
    VALU_ADD,
    VALU_AND,
    VALU_OR,
    VALU_XOR,
    VALU_MIN,
    VALU_MINU,
    VALU_MAX,
    VALU_MAXU
  } aluop_t;

  typedef enum logic [1:0] {
    SEW8,
    SEW16,
    SEW32
  } sew_t;

  // where the first operand comes from
  typedef enum logic [1:0] {
    SRC_V,
    SRC_I,
    SRC_X
  } opsrc_t;

  // load/store access pattern
  typedef enum logic [1:0] {
    STRIDE_UNIT,
    STRIDE_CONST,
    STRIDE_INDEX
  } stride_t;

  typedef logic [4:0] vreg_t;

endpackage
